//--- verilog/trace_enc_params.svh
`ifndef TRACE_ENC_PARAMS_SVH
`define TRACE_ENC_PARAMS_SVH

// instruction address and tval width
`define TRACE_ENC_AW 32

// exception cause width
`define TRACE_ENC_CAUSEW 5

// max branches held before a packet is forced
`define TRACE_ENC_BMAP_DEPTH 31

// apb byte offsets
`define TRACE_ENC_REG_CTRL   8'h00
`define TRACE_ENC_REG_RESYNC 8'h04
`define TRACE_ENC_REG_PKTCNT 8'h08

`endif

//--- verilog/trace_enc_pkg.sv
`default_nettype none

`include "trace_enc_params.svh"

package trace_enc_pkg;

    // format 0 not supported
    typedef enum logic [1:0] {
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } trace_format_e;

    // sync subformats, context (2) left out
    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_SUPPORT = 2'd3
    } trace_sync_sub_e;

    typedef logic [$clog2(`TRACE_ENC_BMAP_DEPTH + 1)-1:0] trace_brcnt_t;
    typedef logic [`TRACE_ENC_BMAP_DEPTH-1:0]             trace_bmap_t;

    // one retired instruction as reported by the core
    typedef struct packed {
        logic [`TRACE_ENC_AW-1:0]     iaddr;
        logic                         is_branch;  // conditional branch
        logic                         taken;
        logic                         updiscon;   // indirect jump
        logic                         exception;
        logic                         retired;
        logic [`TRACE_ENC_CAUSEW-1:0] cause;
        logic [`TRACE_ENC_AW-1:0]     tval;
        logic [1:0]                   priv;
        logic                         qualified;
    } trace_instr_t;

    typedef struct packed {
        trace_instr_t lc;
        trace_instr_t tc;
        trace_instr_t nc;
        logic         enc_enabled;
        logic         enc_disabled;
        logic         step;
    } trace_win_t;

    typedef struct packed {
        trace_format_e   format;
        trace_sync_sub_e subformat;
        logic            thaddr;
        logic            use_tc_cause;  // 0 lc cause/tval, 1 tc
        logic            flush;         // clear branch map
    } trace_decision_t;

    typedef struct packed {
        trace_format_e                format;
        trace_sync_sub_e              subformat;
        trace_brcnt_t                 branches;
        trace_bmap_t                  branch_map;
        logic [`TRACE_ENC_AW-1:0]     address;
        logic                         thaddr;
        logic [`TRACE_ENC_CAUSEW-1:0] cause;
        logic [`TRACE_ENC_AW-1:0]     tval;
        logic [1:0]                   priv;
    } trace_packet_t;

endpackage

`default_nettype wire

//--- verilog/trace_enc_apb_regs.sv
`default_nettype none

`include "trace_enc_params.svh"

module trace_enc_apb_regs (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    input  logic        pkt_accepted_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        enable_o,
    output logic [15:0] resync_max_o
);

    logic        enable_q;
    logic [15:0] resync_q;
    logic [31:0] pktcnt_q;
    logic        access;
    logic        hit_ctrl, hit_resync, hit_pktcnt;

    assign access     = psel_i & penable_i;  // access phase only
    assign hit_ctrl   = paddr_i == `TRACE_ENC_REG_CTRL;
    assign hit_resync = paddr_i == `TRACE_ENC_REG_RESYNC;
    assign hit_pktcnt = paddr_i == `TRACE_ENC_REG_PKTCNT;

    assign pready_o  = 1'b1;  // no wait states
    assign pslverr_o = access & ~(hit_ctrl | hit_resync | hit_pktcnt);

    // read mux, unmapped reads as zero
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl)   prdata_o = {31'b0, enable_q};
        if (hit_resync) prdata_o = {16'b0, resync_q};
        if (hit_pktcnt) prdata_o = pktcnt_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
            resync_q <= 16'h0100;
            pktcnt_q <= '0;
        end else begin
            if (access && pwrite_i && hit_ctrl)   enable_q <= pwdata_i[0];
            if (access && pwrite_i && hit_resync) resync_q <= pwdata_i[15:0];
            if (access && pwrite_i && hit_pktcnt) begin
                pktcnt_q <= '0;  // any write clears
            end else if (pkt_accepted_i) begin
                pktcnt_q <= pktcnt_q + 32'd1;
            end
        end
    end

    assign enable_o     = enable_q;
    assign resync_max_o = resync_q;

endmodule

`default_nettype wire

//--- verilog/trace_enc_window.sv
`default_nettype none

module trace_enc_window import trace_enc_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         enable_i,
    input  logic         trace_valid_i,
    input  trace_instr_t trace_instr_i,
    input  logic         emit_ready_i,
    output logic         trace_ready_o,
    output trace_win_t   win_o,
    output logic         win_step_o
);

    trace_instr_t lc_q, tc_q;  // nc is the incoming item itself
    trace_instr_t nc_slot;
    logic         en_prev_q;   // enable seen at the previous step
    logic         accept, bubble, step;

    assign trace_ready_o = enable_i & emit_ready_i;
    assign accept        = trace_valid_i & trace_ready_o;

    // disabling pushes unqualified bubbles until the enable edge is consumed
    // first one resolves the last instruction, next one reports the disable
    assign bubble  = ~enable_i & en_prev_q & emit_ready_i;
    assign step    = accept | bubble;
    assign nc_slot = bubble ? '0 : trace_instr_i;

    assign win_o.lc           = lc_q;
    assign win_o.tc           = tc_q;
    assign win_o.nc           = nc_slot;
    assign win_o.enc_enabled  = accept & ~en_prev_q;
    assign win_o.enc_disabled = bubble & ~tc_q.qualified;  // last instr already resolved
    assign win_o.step         = step;
    assign win_step_o         = step;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lc_q      <= '0;
            tc_q      <= '0;
            en_prev_q <= 1'b0;
        end else if (step) begin
            lc_q      <= tc_q;  // shift nc -> tc -> lc
            tc_q      <= nc_slot;
            // hold the old enable until the bubble reaches tc
            en_prev_q <= enable_i | (bubble & tc_q.qualified);
        end
    end

    // the core keeps an offered item until the window takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        trace_valid_i && !trace_ready_o |=> trace_valid_i && $stable(trace_instr_i));

endmodule

`default_nettype wire

//--- verilog/trace_enc_branch_map.sv
`default_nettype none

`include "trace_enc_params.svh"

module trace_enc_branch_map import trace_enc_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         win_step_i,
    input  trace_win_t   win_i,
    input  logic         flush_i,
    output trace_brcnt_t br_count_o,
    output trace_bmap_t  br_map_o,
    output logic         br_full_o,
    output logic         br_empty_o
);

    trace_brcnt_t count_q, count_d;
    trace_bmap_t  map_q, map_d;
    logic         record;

    assign record = win_i.tc.qualified & win_i.tc.is_branch;

    always_comb begin
        count_d = count_q;
        map_d   = map_q;
        if (win_step_i) begin
            if (flush_i) begin  // packet sent, restart map
                count_d = '0;
                map_d   = '0;
            end
            if (record) begin
                map_d[count_d] = win_i.tc.taken;  // lands in slot 0 after a flush
                count_d        = count_d + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
            map_q   <= '0;
        end else begin
            count_q <= count_d;
            map_q   <= map_d;
        end
    end

    assign br_count_o = count_q;
    assign br_map_o   = map_q;
    assign br_full_o  = count_q == trace_brcnt_t'(`TRACE_ENC_BMAP_DEPTH);
    assign br_empty_o = count_q == '0;

    // a full map must be flushed by the priority stage before the next branch
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        win_step_i && record && br_full_o |-> flush_i);

endmodule

`default_nettype wire

//--- verilog/trace_enc_priority.sv
`default_nettype none

module trace_enc_priority import trace_enc_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  trace_win_t      win_i,
    input  logic            win_step_i,
    input  logic            br_full_i,
    input  logic            br_empty_i,
    input  logic [15:0]     resync_max_i,
    output logic            dec_valid_o,
    output trace_decision_t dec_o,
    output logic            flush_o
);

    logic [15:0] resync_cnt_q;
    logic        lc_thaddr_q;  // thaddr of the last trap packet
    logic        found;
    logic        tc_exc_only, tc_er_n, tc_privchange, first_qualified;
    logic        resync_hit, resync_br;
    logic        nc_exc_only, nc_privchange_br;
    trace_format_e f12;  // format 1 or 2 depending on pending branches

    assign tc_exc_only      = win_i.tc.exception & ~win_i.tc.retired;
    assign tc_er_n          = win_i.tc.exception & win_i.tc.retired;
    assign tc_privchange    = win_i.tc.priv != win_i.lc.priv;
    assign first_qualified  = ~win_i.lc.qualified;  // tc qualified checked below
    assign resync_hit       = resync_cnt_q >= resync_max_i;
    assign resync_br        = resync_hit & ~br_empty_i;
    assign nc_exc_only      = win_i.nc.exception & ~win_i.nc.retired;
    assign nc_privchange_br = (win_i.nc.priv != win_i.tc.priv) & ~br_empty_i;
    assign f12              = br_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;

    // packet format flowchart for the instruction in tc
    always_comb begin
        found              = 1'b1;
        dec_o.format       = F_SYNC;
        dec_o.subformat    = SF_START;
        dec_o.thaddr       = 1'b0;
        dec_o.use_tc_cause = 1'b0;
        if (win_i.enc_enabled || win_i.enc_disabled) begin
            dec_o.subformat = SF_SUPPORT;
        end else if (!win_i.tc.qualified) begin
            found = 1'b0;
        end else if (win_i.lc.exception) begin
            if (tc_exc_only) begin
                dec_o.subformat = SF_TRAP;  // thaddr 0, lc cause
            end else if (!lc_thaddr_q) begin
                dec_o.subformat = SF_START;  // trap already reported
            end else begin
                dec_o.subformat = SF_TRAP;
                dec_o.thaddr    = 1'b1;
            end
        end else if (first_qualified || tc_privchange || (resync_hit && br_empty_i)) begin
            dec_o.subformat = SF_START;  // pending branches on resync go out first
        end else if (win_i.lc.updiscon) begin
            if (tc_exc_only) begin
                dec_o.subformat    = SF_TRAP;
                dec_o.use_tc_cause = 1'b1;
            end else begin
                dec_o.format = f12;
            end
        end else if (resync_br || tc_er_n) begin
            dec_o.format = F_DIFF_DELTA;
        end else if (nc_exc_only || nc_privchange_br || !win_i.nc.qualified) begin
            dec_o.format = f12;
        end else if (br_full_i) begin
            dec_o.format = F_DIFF_DELTA;
        end else begin
            found = 1'b0;
        end
        dec_o.flush = win_step_i & found;  // every packet empties the map
    end

    assign dec_valid_o = win_step_i & found;
    assign flush_o     = dec_o.flush;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resync_cnt_q <= '0;
            lc_thaddr_q  <= 1'b0;
        end else if (win_step_i) begin
            if (dec_valid_o && dec_o.format == F_SYNC) begin
                resync_cnt_q <= '0;
            end else if (win_i.tc.qualified) begin
                resync_cnt_q <= resync_cnt_q + 16'd1;
            end
            if (dec_valid_o && dec_o.format == F_SYNC && dec_o.subformat == SF_TRAP) begin
                lc_thaddr_q <= dec_o.thaddr;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/trace_enc_emitter.sv
`default_nettype none

module trace_enc_emitter import trace_enc_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  trace_win_t      win_i,
    input  logic            win_step_i,
    input  logic            dec_valid_i,
    input  trace_decision_t dec_i,
    input  trace_brcnt_t    br_count_i,
    input  trace_bmap_t     br_map_i,
    input  logic            pkt_ready_i,
    output logic            emit_ready_o,
    output logic            pkt_valid_o,
    output trace_packet_t   pkt_o,
    output logic            pkt_accepted_o
);

    trace_packet_t pkt_d, pkt_q;
    logic          valid_q;
    logic          load;

    assign load = win_step_i & dec_valid_i;

    // payload from the window and the map as it was before this step
    always_comb begin
        pkt_d.format     = dec_i.format;
        pkt_d.subformat  = dec_i.subformat;
        pkt_d.branches   = br_count_i;
        pkt_d.branch_map = br_map_i;
        pkt_d.address    = win_i.tc.iaddr;  // full address, no diff
        pkt_d.thaddr     = dec_i.thaddr;
        pkt_d.cause      = dec_i.use_tc_cause ? win_i.tc.cause : win_i.lc.cause;
        pkt_d.tval       = dec_i.use_tc_cause ? win_i.tc.tval : win_i.lc.tval;
        pkt_d.priv       = win_i.tc.priv;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (pkt_ready_i) begin
            valid_q <= 1'b0;  // taken by the sink
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) pkt_q <= pkt_d;
    end

    // single slot, free when empty or draining this cycle
    assign emit_ready_o   = ~valid_q | pkt_ready_i;
    assign pkt_valid_o    = valid_q;
    assign pkt_o          = pkt_q;
    assign pkt_accepted_o = valid_q & pkt_ready_i;

    // stalled packet holds and the window does not move under it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_o && !pkt_ready_i |-> !win_i.step ##1 pkt_valid_o && $stable(pkt_o));

endmodule

`default_nettype wire

//--- verilog/trace_enc_top.sv
`default_nettype none

module trace_enc_top import trace_enc_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [7:0]    paddr_i,
    input  logic [31:0]   pwdata_i,
    output logic [31:0]   prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,
    input  logic          trace_valid_i,
    input  trace_instr_t  trace_instr_i,
    output logic          trace_ready_o,
    output logic          pkt_valid_o,
    input  logic          pkt_ready_i,
    output trace_packet_t pkt_o
);

    trace_win_t      win;
    trace_decision_t dec;
    trace_brcnt_t    br_count;
    trace_bmap_t     br_map;
    logic            win_step, br_full, br_empty;
    logic            dec_valid, flush, emit_ready, pkt_accepted, enable;
    logic [15:0]     resync_max;

    trace_enc_apb_regs u_apb_regs (
        .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .pkt_accepted_i (pkt_accepted),
        .prdata_o, .pready_o, .pslverr_o,
        .enable_o       (enable),
        .resync_max_o   (resync_max)
    );

    trace_enc_window u_window (
        .clk_i, .rst_ni, .trace_valid_i, .trace_instr_i, .trace_ready_o,
        .enable_i     (enable),
        .emit_ready_i (emit_ready),
        .win_o        (win),
        .win_step_o   (win_step)
    );

    trace_enc_branch_map u_branch_map (
        .clk_i, .rst_ni,
        .win_step_i (win_step),
        .win_i      (win),
        .flush_i    (flush),
        .br_count_o (br_count),
        .br_map_o   (br_map),
        .br_full_o  (br_full),
        .br_empty_o (br_empty)
    );

    trace_enc_priority u_priority (
        .clk_i, .rst_ni,
        .win_i        (win),
        .win_step_i   (win_step),
        .br_full_i    (br_full),
        .br_empty_i   (br_empty),
        .resync_max_i (resync_max),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec),
        .flush_o      (flush)
    );

    trace_enc_emitter u_emitter (
        .clk_i, .rst_ni, .pkt_ready_i, .pkt_valid_o, .pkt_o,
        .win_i          (win),
        .win_step_i     (win_step),
        .dec_valid_i    (dec_valid),
        .dec_i          (dec),
        .br_count_i     (br_count),
        .br_map_i       (br_map),
        .emit_ready_o   (emit_ready),
        .pkt_accepted_o (pkt_accepted)
    );

endmodule

`default_nettype wire

//--- dv/trace_enc_tb.sv
`default_nettype none

`include "trace_enc_params.svh"

module trace_enc_tb import trace_enc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         TIMEOUT_CYCLES = 20000;  // ~1200 instrs, stalls, apb
    localparam logic [1:0] PRIV           = 2'b11;  // all traffic in one mode

    logic          clk_i;
    logic          rst_ni;
    logic          psel_i, penable_i, pwrite_i;
    logic [7:0]    paddr_i;
    logic [31:0]   pwdata_i, prdata_o;
    logic          pready_o, pslverr_o;
    logic          trace_valid_i, trace_ready_o;
    trace_instr_t  trace_instr_i;
    logic          pkt_valid_o, pkt_ready_i;
    trace_packet_t pkt_o;

    trace_packet_t exp_q[$];  // packets still to come, oldest first
    int            n_accepted;
    int            cycles;
    logic [31:0]   pc;        // address of the next instruction to send

    trace_enc_top uut (.*);

    always #50 clk_i = ~clk_i;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %0d ns %s got 'h%0h expected 'h%0h",
                                $time, name, got, exp));
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // random sink, handshake is decided here and taken on the next rising edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            pkt_ready_i = $urandom_range(99) < 60;
            if (pkt_valid_o && pkt_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("a packet came out that no stimulus asked for");
                end else begin
                    check_eq("pkt_o", pkt_o, exp_q.pop_front());
                    n_accepted++;
                end
            end
        end
    end

    // a stalled packet keeps its value
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_o && !pkt_ready_i |=> pkt_valid_o && $stable(pkt_o))
    else abort_run("pkt_o or pkt_valid_o changed while the sink stalled");

    // window must not take an instruction under a stall
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_o && !pkt_ready_i |-> !(trace_valid_i && trace_ready_o))
    else abort_run("an instruction was accepted while the packet output stalled");

    assert property (@(posedge clk_i) disable iff (!rst_ni) pready_o)
    else abort_run("pready_o dropped");

    function automatic trace_instr_t make_instr(input logic [31:0] addr);
        trace_instr_t ins;
        ins           = '0;
        ins.iaddr     = addr;
        ins.priv      = PRIV;
        ins.qualified = 1'b1;
        return ins;
    endfunction

    function automatic trace_packet_t make_pkt(input trace_format_e fmt,
                                               input trace_sync_sub_e sub,
                                               input int nbr, input trace_bmap_t map,
                                               input logic [31:0] addr,
                                               input logic [1:0] priv);
        trace_packet_t p;
        p            = '0;     // cause, tval, thaddr zero unless set by caller
        p.format     = fmt;
        p.subformat  = sub;    // unused field stays 0 for formats 1 and 2
        p.branches   = trace_brcnt_t'(nbr);
        p.branch_map = map;
        p.address    = addr;
        p.priv       = priv;
        return p;
    endfunction

    // setup cycle, one access cycle, sample on the falling edge after it
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        @(negedge clk_i);
        rdata     = prdata_o;
        err       = pslverr_o;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_eq("pslverr_o", err, 1'b0);
    endtask

    task automatic send_instr(input trace_instr_t ins);
        int gap;
        gap = $urandom_range(2);
        repeat (gap) @(negedge clk_i);  // idle cycles between items
        trace_valid_i = 1'b1;
        trace_instr_i = ins;
        do begin
            @(posedge clk_i);
        end while (!trace_ready_o);
        @(negedge clk_i);
        trace_valid_i = 1'b0;
    endtask

    task automatic send_plain(input int n);
        repeat (n) begin
            send_instr(make_instr(pc));
            pc += 4;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pkt_valid_o) @(negedge clk_i);
    endtask

    // k branches then an indirect jump, packet lands on the target
    task automatic run_jump(input int k);
        trace_instr_t ins;
        trace_bmap_t  map;
        logic [31:0]  target;
        map    = '0;
        target = $urandom() & 32'hffff_fffc;
        for (int i = 0; i < k; i++) begin
            ins           = make_instr(pc);
            ins.is_branch = 1'b1;
            ins.taken     = $urandom_range(1);
            map[i]        = ins.taken;
            send_instr(ins);
            pc += 4;
        end
        if (k == 0) begin
            exp_q.push_back(make_pkt(F_ADDR_ONLY, SF_START, 0, '0, target, PRIV));
        end else begin
            exp_q.push_back(make_pkt(F_DIFF_DELTA, SF_START, k, map, target, PRIV));
        end
        ins          = make_instr(pc);
        ins.updiscon = 1'b1;
        send_instr(ins);
        pc = target;
        send_plain(2);  // target, then the one that resolves it
    endtask

    task automatic run_full_map();
        trace_instr_t ins;
        trace_bmap_t  map;
        map = '0;
        for (int i = 0; i < `TRACE_ENC_BMAP_DEPTH; i++) begin
            ins           = make_instr(pc);
            ins.is_branch = 1'b1;
            ins.taken     = $urandom_range(1);
            map[i]        = ins.taken;
            send_instr(ins);
            pc += 4;
        end
        // reported on the first instruction after the last branch
        exp_q.push_back(make_pkt(F_DIFF_DELTA, SF_START, `TRACE_ENC_BMAP_DEPTH, map, pc, PRIV));
        send_plain(2);
    endtask

    // retired exception, then exception only, then handler code
    task automatic run_trap();
        trace_instr_t  e1, e2;
        trace_packet_t p;
        e1           = make_instr(pc);
        e1.exception = 1'b1;
        e1.retired   = 1'b1;
        e1.cause     = $urandom_range(31);
        e1.tval      = $urandom();
        e2           = make_instr(pc + 4);
        e2.exception = 1'b1;
        e2.cause     = $urandom_range(31);
        e2.tval      = $urandom();
        exp_q.push_back(make_pkt(F_DIFF_DELTA, SF_START, 0, '0, e1.iaddr, PRIV));
        p       = make_pkt(F_SYNC, SF_TRAP, 0, '0, e2.iaddr, PRIV);
        p.cause = e1.cause;  // thaddr 0, cause of the first one
        p.tval  = e1.tval;
        exp_q.push_back(p);
        p       = make_pkt(F_SYNC, SF_START, 0, '0, pc + 8, PRIV);
        p.cause = e2.cause;
        p.tval  = e2.tval;
        exp_q.push_back(p);
        send_instr(e1);
        send_instr(e2);
        pc += 8;
        send_plain(2);
    endtask

    task automatic enable_encoder();
        exp_q.push_back(make_pkt(F_SYNC, SF_SUPPORT, 0, '0, '0, 2'b00));
        exp_q.push_back(make_pkt(F_SYNC, SF_START, 0, '0, pc, PRIV));
        reg_write(`TRACE_ENC_REG_CTRL, 32'h1);
        send_plain(2);
    endtask

    // last instruction resolved by the bubble, then the support packet
    task automatic disable_encoder();
        exp_q.push_back(make_pkt(F_ADDR_ONLY, SF_START, 0, '0, pc - 4, PRIV));
        exp_q.push_back(make_pkt(F_SYNC, SF_SUPPORT, 0, '0, '0, 2'b00));
        reg_write(`TRACE_ENC_REG_CTRL, 32'h0);
        wait_drain();
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        void'($urandom(32'haae5));
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        trace_valid_i = 1'b0;
        trace_instr_i = '0;
        pkt_ready_i   = 1'b0;
        n_accepted    = 0;
        cycles        = 0;
        pc            = 32'h0000_1000;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_eq("trace_ready_o", trace_ready_o, 1'b0);
        check_eq("pkt_valid_o", pkt_valid_o, 1'b0);
        check_eq("pslverr_o", pslverr_o, 1'b0);

        // resync far away so no periodic sync disturbs the expected stream
        reg_write(`TRACE_ENC_REG_RESYNC, 32'h0000_ffff);
        apb_access(1'b0, `TRACE_ENC_REG_RESYNC, '0, rdata, err);
        check_eq("prdata_o", rdata, 32'h0000_ffff);
        apb_access(1'b0, 8'h0c, '0, rdata, err);
        check_eq("pslverr_o", err, 1'b1);

        enable_encoder();
        for (int i = 0; i < 120; i++) begin
            case ($urandom_range(5))
                0: send_plain($urandom_range(6, 1));
                1: run_jump(0);
                2: run_jump($urandom_range(20, 1));
                3: run_full_map();
                4: run_trap();
                default: begin
                    disable_encoder();
                    enable_encoder();
                end
            endcase
        end
        disable_encoder();

        apb_access(1'b0, `TRACE_ENC_REG_PKTCNT, '0, rdata, err);
        check_eq("prdata_o", rdata, n_accepted);
        repeat (20) @(negedge clk_i);  // a stray packet would hit the sink
        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("some expected packets were never emitted");
        end
    end

endmodule

`default_nettype wire

//--- trace_enc.f
+incdir+verilog
verilog/trace_enc_pkg.sv
verilog/trace_enc_apb_regs.sv
verilog/trace_enc_window.sv
verilog/trace_enc_branch_map.sv
verilog/trace_enc_priority.sv
verilog/trace_enc_emitter.sv
verilog/trace_enc_top.sv
dv/trace_enc_tb.sv
